// File: filelist.f
logic/cache_cfg_pkg.sv
logic/cache_op_pkg.sv
logic/cache_miss_if.sv
logic/cache_decode.sv
logic/cache_lookup.sv
logic/cache_miss.sv
logic/cache_load_align.sv
logic/cache_top.sv
tb/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
  import cache_cfg_pkg::*;
  import cache_op_pkg::*;

  typedef struct packed {
    cache_op_e   op;
    logic [15:0] addr;
    word_t       wdata;
    word_t       exp;
    logic        fill;
    logic        wb;
    logic [15:0] wb_addr;
  } test_row_s;

  localparam int cycles_per_row_c = 40;

  logic        clk_i;
  logic        reset_i;
  cache_op_e   cache_op_i;
  logic [15:0] addr_i;
  word_t       data_i;
  logic        v_i;
  logic        ready_o;
  word_t       data_o;
  logic        v_o;
  logic        yumi_i;
  logic        mem_v_o;
  logic        mem_w_o;
  logic [15:0] mem_addr_o;
  logic        mem_yumi_i;
  word_t       mem_wdata_o;
  logic        mem_wdata_v_o;
  logic        mem_wdata_yumi_i;
  word_t       mem_rdata_i;
  logic        mem_rdata_v_i;

  logic [7:0]   ref_bytes [0:65535];
  word_t        mem_words [0:16383];
  test_row_s    rows [$];
  logic [127:0] wb_exp [$];

  integer       seed = 32'h7acd7bdb;
  int           errors = 0;
  int           passed = 0;
  int           failed = 0;
  int           done_count = 0;
  int           fill_count = 0;
  int           wb_count = 0;
  int           cycles = 0;
  logic [15:0]  last_fill_addr;
  logic [15:0]  last_wb_addr;
  logic [127:0] last_wb_data;

  cache_top UUT (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cache_op_i       (cache_op_i),
    .addr_i           (addr_i),
    .data_i           (data_i),
    .v_i              (v_i),
    .ready_o          (ready_o),
    .data_o           (data_o),
    .v_o              (v_o),
    .yumi_i           (yumi_i),
    .mem_v_o          (mem_v_o),
    .mem_w_o          (mem_w_o),
    .mem_addr_o       (mem_addr_o),
    .mem_yumi_i       (mem_yumi_i),
    .mem_wdata_o      (mem_wdata_o),
    .mem_wdata_v_o    (mem_wdata_v_o),
    .mem_wdata_yumi_i (mem_wdata_yumi_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_rdata_v_i    (mem_rdata_v_i)
  );

  // byte 4w+i sits in bits 8i+7:8i of word w
  function automatic word_t ref_word(input logic [15:0] addr);
    logic [15:0] a;
    a = {addr[15:2], 2'b00};
    return {ref_bytes[a + 16'd3], ref_bytes[a + 16'd2], ref_bytes[a + 16'd1], ref_bytes[a]};
  endfunction

  function automatic word_t ref_load(input cache_op_e op, input logic [15:0] addr);
    logic [15:0] a;
    logic [15:0] half;
    a = {addr[15:1], 1'b0};
    half = {ref_bytes[a + 16'd1], ref_bytes[a]};
    case (op)
      op_lb:   return {{24{ref_bytes[addr][7]}}, ref_bytes[addr]};
      op_lbu:  return {24'd0, ref_bytes[addr]};
      op_lh:   return {{16{half[15]}}, half};
      op_lhu:  return {16'd0, half};
      op_lw:   return ref_word(addr);
      default: return '0;
    endcase
  endfunction

  task automatic ref_store(input cache_op_e op, input logic [15:0] addr, input word_t wdata);
    logic [15:0] a;
    case (op)
      op_sb: begin
        ref_bytes[addr] = wdata[7:0];
      end
      op_sh: begin
        a = {addr[15:1], 1'b0};
        ref_bytes[a] = wdata[7:0];
        ref_bytes[a + 16'd1] = wdata[15:8];
      end
      op_sw: begin
        a = {addr[15:2], 2'b00};
        ref_bytes[a] = wdata[7:0];
        ref_bytes[a + 16'd1] = wdata[15:8];
        ref_bytes[a + 16'd2] = wdata[23:16];
        ref_bytes[a + 16'd3] = wdata[31:24];
      end
      default: begin
      end
    endcase
  endtask

  task automatic init_models();
    word_t w;
    for (int i = 0; i < 16384; i++) begin
      mem_words[14'(i)] = 32'(i) * 32'h01010101 + 32'h5a;
    end
    for (int b = 0; b < 65536; b++) begin
      w = 32'(b >> 2) * 32'h01010101 + 32'h5a;
      ref_bytes[16'(b)] = 8'(w >> (8 * (b & 3)));
    end
  endtask

  task automatic add_row(input cache_op_e op, input logic [15:0] addr, input word_t wdata,
                         input logic fill, input logic wb, input logic [15:0] wb_addr);
    test_row_s row;
    row.op      = op;
    row.addr    = addr;
    row.wdata   = wdata;
    row.exp     = ref_load(op, addr);
    row.fill    = fill;
    row.wb      = wb;
    row.wb_addr = wb_addr;
    rows.push_back(row);
    wb_exp.push_back({ref_word(wb_addr + 16'd12), ref_word(wb_addr + 16'd8),
                      ref_word(wb_addr + 16'd4), ref_word(wb_addr)});
    ref_store(op, addr, wdata);
  endtask

  task automatic build_table();
    // cold load
    add_row(op_lw,  16'h0100, 32'h0, 1'b1, 1'b0, 16'h0);
    // extension of bytes and halves
    add_row(op_lb,  16'h9c31, 32'h0, 1'b1, 1'b0, 16'h0);
    add_row(op_lbu, 16'h9c33, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lh,  16'h9c36, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lhu, 16'h9c3a, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lw,  16'h9c3c, 32'h0, 1'b0, 1'b0, 16'h0);
    // partial stores merged into words
    add_row(op_sb,  16'h9c35, 32'h123456a5, 1'b0, 1'b0, 16'h0);
    add_row(op_sh,  16'h9c3a, 32'h0000c3e1, 1'b0, 1'b0, 16'h0);
    add_row(op_lw,  16'h9c34, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lw,  16'h9c38, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lh,  16'h9c3a, 32'h0, 1'b0, 1'b0, 16'h0);
    // dirty block 0x1150 in set 5 pushed out by 0x2250 and 0x3350
    add_row(op_sw,  16'h1150, 32'hdead0001, 1'b1, 1'b0, 16'h0);
    add_row(op_sw,  16'h1154, 32'hdead0002, 1'b0, 1'b0, 16'h0);
    add_row(op_sw,  16'h1158, 32'hdead0003, 1'b0, 1'b0, 16'h0);
    add_row(op_sw,  16'h115c, 32'hdead0004, 1'b0, 1'b0, 16'h0);
    add_row(op_lw,  16'h2250, 32'h0, 1'b1, 1'b0, 16'h0);
    add_row(op_lw,  16'h3354, 32'h0, 1'b1, 1'b1, 16'h1150);
    add_row(op_lw,  16'h115c, 32'h0, 1'b1, 1'b0, 16'h0);
    add_row(op_lw,  16'h1150, 32'h0, 1'b0, 1'b0, 16'h0);
    // A B A in set 9 and then C replaces B
    add_row(op_lw,  16'h4490, 32'h0, 1'b1, 1'b0, 16'h0);
    add_row(op_lw,  16'h5590, 32'h0, 1'b1, 1'b0, 16'h0);
    add_row(op_lw,  16'h4490, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lw,  16'h6690, 32'h0, 1'b1, 1'b0, 16'h0);
    add_row(op_lw,  16'h4494, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lw,  16'h5598, 32'h0, 1'b1, 1'b0, 16'h0);
    // back-to-back hits
    add_row(op_lhu, 16'h9c3a, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lb,  16'h9c35, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lbu, 16'h9c35, 32'h0, 1'b0, 1'b0, 16'h0);
    add_row(op_lh,  16'h0102, 32'h0, 1'b0, 1'b0, 16'h0);
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  initial begin : stimulus
    reset_i    = 1'b1;
    v_i        = 1'b0;
    cache_op_i = op_lw;
    addr_i     = '0;
    data_i     = '0;
    init_models();
    build_table();
    repeat (3) @(posedge clk_i);
    #5;
    reset_i = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      cache_op_i = rows[i].op;
      addr_i     = rows[i].addr;
      data_i     = rows[i].wdata;
      v_i        = 1'b1;
      @(negedge clk_i);
      while (!ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #5;
    end
    v_i = 1'b0;
    wait (done_count == rows.size());
    @(posedge clk_i);
    $display("tests %0d, passed %0d, failed %0d, errors %0d", rows.size(), passed, failed,
             errors);
    if (errors == 0) begin
      $display("Regression passed");
    end
    else begin
      $display("Regression failed");
    end
    $finish;
  end

  // random yumi_i with responses sampled mid-cycle
  initial begin : response_check
    test_row_s row;
    cache_op_e op;
    logic      held_v;
    word_t     held_data;
    int        err_mark;
    int        fill_mark;
    int        wb_mark;
    yumi_i    = 1'b0;
    held_v    = 1'b0;
    held_data = '0;
    err_mark  = 0;
    fill_mark = 0;
    wb_mark   = 0;
    @(negedge reset_i);
    forever begin
      @(posedge clk_i);
      #5;
      yumi_i = ($random(seed) & 3) != 0;
      @(negedge clk_i);
      if (held_v) begin
        assert (v_o && data_o == held_data) else begin
          $display("ERROR @ %0d ns: response changed while yumi_i was low", $time);
          errors++;
        end
      end
      held_v    = v_o && !yumi_i;
      held_data = data_o;
      if (v_o && yumi_i && done_count >= rows.size()) begin
        $display("the cache returned a response that no request asked for");
        errors++;
      end
      else if (v_o && yumi_i) begin
        row = rows[done_count];
        op  = row.op;
        assert (data_o == row.exp) else begin
          $display("ERROR @ %0d ns: test %0d data_o %h, expected %h", $time, done_count,
                   data_o, row.exp);
          errors++;
        end
        assert (fill_count - fill_mark == int'(row.fill)) else begin
          $display("ERROR @ %0d ns: test %0d made %0d fill requests, expected %0d", $time,
                   done_count, fill_count - fill_mark, row.fill);
          errors++;
        end
        if (row.fill) begin
          assert (last_fill_addr == {row.addr[15:4], 4'h0}) else begin
            $display("ERROR @ %0d ns: test %0d fill address %h", $time, done_count,
                     last_fill_addr);
            errors++;
          end
        end
        assert (wb_count - wb_mark == int'(row.wb)) else begin
          $display("ERROR @ %0d ns: test %0d made %0d write-backs, expected %0d", $time,
                   done_count, wb_count - wb_mark, row.wb);
          errors++;
        end
        if (row.wb) begin
          assert (last_wb_addr == row.wb_addr && last_wb_data == wb_exp[done_count]) else begin
            $display("ERROR @ %0d ns: test %0d write-back %h data %h, expected %h data %h",
                     $time, done_count, last_wb_addr, last_wb_data, row.wb_addr,
                     wb_exp[done_count]);
            errors++;
          end
        end
        $display("test %0d %s addr %h: %s", done_count, op.name(), row.addr,
                 (errors == err_mark) ? "ok" : "FAILED");
        if (errors == err_mark) begin
          passed++;
        end
        else begin
          failed++;
        end
        err_mark  = errors;
        fill_mark = fill_count;
        wb_mark   = wb_count;
        done_count++;
      end
    end
  end

  initial begin : memory_model
    logic [15:0]  req_addr;
    logic         req_write;
    logic [127:0] wb_buf;
    int           wait_cycles;
    mem_yumi_i       = 1'b0;
    mem_wdata_yumi_i = 1'b0;
    mem_rdata_v_i    = 1'b0;
    mem_rdata_i      = '0;
    wb_buf           = '0;
    forever begin
      @(negedge clk_i);
      if (mem_v_o) begin
        req_addr  = mem_addr_o;
        req_write = mem_w_o;
        assert (req_addr[3:0] == 4'h0) else begin
          $display("ERROR @ %0d ns: memory address %h not block-aligned", $time, req_addr);
          errors++;
        end
        wait_cycles = $unsigned($random(seed)) % 4;
        repeat (wait_cycles) @(posedge clk_i);
        @(posedge clk_i);
        #5;
        mem_yumi_i = 1'b1;
        @(posedge clk_i);
        #5;
        mem_yumi_i = 1'b0;
        if (req_write) begin
          mem_wdata_yumi_i = 1'b1;
          for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            assert (mem_wdata_v_o) else begin
              $display("write-back word %0d was not offered after the write request", i);
              errors++;
            end
            wb_buf = {mem_wdata_o, wb_buf[127:32]};
            mem_words[req_addr[15:2] + 14'(i)] = mem_wdata_o;
            @(posedge clk_i);
          end
          #5;
          mem_wdata_yumi_i = 1'b0;
          last_wb_addr     = req_addr;
          last_wb_data     = wb_buf;
          wb_count++;
        end
        else begin
          for (int i = 0; i < 4; i++) begin
            mem_rdata_v_i = 1'b1;
            mem_rdata_i   = mem_words[req_addr[15:2] + 14'(i)];
            @(posedge clk_i);
            #5;
          end
          mem_rdata_v_i  = 1'b0;
          last_fill_addr = req_addr;
          fill_count++;
        end
      end
    end
  end

  initial begin : watchdog
    int limit;
    @(negedge reset_i);
    limit = cycles_per_row_c * rows.size();
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: after %0d cycles only %0d of %0d responses had arrived", limit,
             done_count, rows.size());
    $display("Regression failed");
    $finish;
  end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/1ps

module cache_top (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  cache_op_pkg::cache_op_e                cache_op_i,
  input  logic [cache_cfg_pkg::addr_width_c-1:0] addr_i,
  input  cache_cfg_pkg::word_t                   data_i,
  input  logic                                   v_i,
  output logic                                   ready_o,
  output cache_cfg_pkg::word_t                   data_o,
  output logic                                   v_o,
  input  logic                                   yumi_i,
  output logic                                   mem_v_o,
  output logic                                   mem_w_o,
  output logic [cache_cfg_pkg::addr_width_c-1:0] mem_addr_o,
  input  logic                                   mem_yumi_i,
  output cache_cfg_pkg::word_t                   mem_wdata_o,
  output logic                                   mem_wdata_v_o,
  input  logic                                   mem_wdata_yumi_i,
  input  cache_cfg_pkg::word_t                   mem_rdata_i,
  input  logic                                   mem_rdata_v_i
);
  import cache_cfg_pkg::*;
  import cache_op_pkg::*;

  logic          tl_v;
  cache_decode_s tl_decode;
  cache_addr_u   tl_addr;
  word_t         tl_data;
  logic          advance;
  cache_decode_s tv_decode;
  cache_addr_u   tv_addr;
  word_t         hit_word;

  cache_miss_if miss_if ();

  cache_decode decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cache_op_i  (cache_op_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .v_i         (v_i),
    .ready_o     (ready_o),
    .advance_i   (advance),
    .tl_v_o      (tl_v),
    .tl_decode_o (tl_decode),
    .tl_addr_o   (tl_addr),
    .tl_data_o   (tl_data)
  );

  // v_o only rises on a hit
  cache_lookup lookup (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tl_v_i      (tl_v),
    .tl_decode_i (tl_decode),
    .tl_addr_i   (tl_addr),
    .tl_data_i   (tl_data),
    .yumi_i      (yumi_i),
    .advance_o   (advance),
    .tv_v_o      (v_o),
    .tv_decode_o (tv_decode),
    .tv_addr_o   (tv_addr),
    .hit_word_o  (hit_word),
    .miss        (miss_if.lookup)
  );

  cache_miss miss (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .miss             (miss_if.miss),
    .mem_v_o          (mem_v_o),
    .mem_w_o          (mem_w_o),
    .mem_addr_o       (mem_addr_o),
    .mem_yumi_i       (mem_yumi_i),
    .mem_wdata_o      (mem_wdata_o),
    .mem_wdata_v_o    (mem_wdata_v_o),
    .mem_wdata_yumi_i (mem_wdata_yumi_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_rdata_v_i    (mem_rdata_v_i)
  );

  cache_load_align align (
    .tv_decode_i (tv_decode),
    .byte_off_i  (tv_addr.f.byte_off),
    .hit_word_i  (hit_word),
    .data_o      (data_o)
  );

endmodule

// File: logic/cache_load_align.sv
`timescale 1ns/1ps

module cache_load_align (
  input  cache_op_pkg::cache_decode_s          tv_decode_i,
  input  logic [cache_cfg_pkg::byte_off_c-1:0] byte_off_i,
  input  cache_cfg_pkg::word_t                 hit_word_i,
  output cache_cfg_pkg::word_t                 data_o
);
  import cache_cfg_pkg::*;
  import cache_op_pkg::*;

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign byte_sel = hit_word_i[8*byte_off_i +: 8];
  assign half_sel = hit_word_i[16*byte_off_i[1] +: 16];

  always_comb begin
    if (tv_decode_i.st_op) begin
      data_o = '0;
    end
    else begin
      case (tv_decode_i.size)
        size_byte: data_o = {{(word_width_c-8){tv_decode_i.sigext & byte_sel[7]}}, byte_sel};
        size_half: data_o = {{(word_width_c-16){tv_decode_i.sigext & half_sel[15]}}, half_sel};
        default:   data_o = hit_word_i;
      endcase
    end
  end

endmodule

// File: logic/cache_miss.sv
`timescale 1ns/1ps

module cache_miss (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  cache_miss_if.miss                              miss,
  output logic                                    mem_v_o,
  output logic                                    mem_w_o,
  output logic [cache_cfg_pkg::addr_width_c-1:0]  mem_addr_o,
  input  logic                                    mem_yumi_i,
  output cache_cfg_pkg::word_t                    mem_wdata_o,
  output logic                                    mem_wdata_v_o,
  input  logic                                    mem_wdata_yumi_i,
  input  cache_cfg_pkg::word_t                    mem_rdata_i,
  input  logic                                    mem_rdata_v_i
);
  import cache_cfg_pkg::*;

  typedef enum logic [2:0] {
    idle_s,
    wb_req_s,
    wb_data_s,
    fill_req_s,
    fill_data_s,
    tag_wr_s
  } miss_state_e;

  miss_state_e            state_r;
  logic [lg_block_c-1:0]  cnt_r;
  logic [lg_ways_c-1:0]   victim_way;
  logic [lg_ways_c-1:0]   victim_way_r;
  logic [tag_width_c-1:0] victim_tag_r;
  logic                   victim_dirty;
  logic                   last_word;
  cache_addr_u            mem_addr;

  // prefer an invalid way over the lru way
  always_comb begin
    if (!miss.meta[0].valid) begin
      victim_way = 1'b0;
    end
    else if (!miss.meta[1].valid) begin
      victim_way = 1'b1;
    end
    else begin
      victim_way = miss.stat.lru;
    end
  end

  assign victim_dirty = miss.stat.dirty[victim_way] & miss.meta[victim_way].valid;
  assign last_word    = (cnt_r == lg_block_c'(block_words_c - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= idle_s;
      cnt_r   <= '0;
    end
    else begin
      case (state_r)
        idle_s: begin
          if (miss.miss_v) begin
            state_r <= victim_dirty ? wb_req_s : fill_req_s;
          end
        end
        wb_req_s: begin
          if (mem_yumi_i) begin
            state_r <= wb_data_s;
          end
        end
        wb_data_s: begin
          if (mem_wdata_yumi_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              state_r <= fill_req_s;
            end
          end
        end
        fill_req_s: begin
          if (mem_yumi_i) begin
            state_r <= fill_data_s;
          end
        end
        fill_data_s: begin
          if (mem_rdata_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              state_r <= tag_wr_s;
            end
          end
        end
        default: state_r <= idle_s;
      endcase
    end
  end

  // victim held for the whole miss
  always_ff @(posedge clk_i) begin
    if (state_r == idle_s && miss.miss_v) begin
      victim_way_r <= victim_way;
      victim_tag_r <= miss.meta[victim_way].tag;
    end
  end

  // block address carrying the victim tag on write-back
  always_comb begin
    mem_addr            = miss.miss_addr;
    mem_addr.f.word_off = '0;
    mem_addr.f.byte_off = '0;
    if (state_r == wb_req_s) begin
      mem_addr.f.tag = victim_tag_r;
    end
  end

  assign mem_v_o       = (state_r == wb_req_s) | (state_r == fill_req_s);
  assign mem_w_o       = (state_r == wb_req_s);
  assign mem_addr_o    = mem_addr.flat;
  assign mem_wdata_v_o = (state_r == wb_data_s);
  assign mem_wdata_o   = miss.evict_data;

  assign miss.evict_offset = cnt_r;
  assign miss.fill_way     = victim_way_r;
  assign miss.fill_we      = (state_r == fill_data_s) & mem_rdata_v_i;
  assign miss.fill_offset  = cnt_r;
  assign miss.fill_data    = mem_rdata_i;
  assign miss.done         = (state_r == tag_wr_s);

  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_v_o && !mem_yumi_i |=> mem_v_o && $stable(mem_addr_o))
    else $error("memory request dropped or changed before yumi");

endmodule

// File: logic/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        tl_v_i,
  input  cache_op_pkg::cache_decode_s tl_decode_i,
  input  cache_cfg_pkg::cache_addr_u  tl_addr_i,
  input  cache_cfg_pkg::word_t        tl_data_i,
  input  logic                        yumi_i,
  output logic                        advance_o,
  output logic                        tv_v_o,
  output cache_op_pkg::cache_decode_s tv_decode_o,
  output cache_cfg_pkg::cache_addr_u  tv_addr_o,
  output cache_cfg_pkg::word_t        hit_word_o,
  cache_miss_if.lookup                miss
);
  import cache_cfg_pkg::*;
  import cache_op_pkg::*;

  logic          tv_v_r;
  cache_decode_s tv_decode_r;
  cache_addr_u   tv_addr_r;
  word_t         tv_data_r;

  way_meta_s [ways_c-1:0] meta_r [sets_c];
  set_stat_s              stat_r [sets_c];
  word_t                  data_r [sets_c][ways_c][block_words_c];

  logic [lg_sets_c-1:0]      idx;
  logic [ways_c-1:0]         hit_v;
  logic                      hit_found;
  logic [lg_ways_c-1:0]      hit_way;
  logic                      retire;
  logic [word_width_c/8-1:0] byte_en;
  word_t                     st_word;

  assign idx = tv_addr_r.f.index;

  // compare against live array contents
  for (genvar w = 0; w < ways_c; w++) begin : g_cmp
    assign hit_v[w] = meta_r[idx][w].valid & (meta_r[idx][w].tag == tv_addr_r.f.tag);
  end

  assign hit_found = |hit_v;
  assign hit_way   = hit_v[1];
  assign tv_v_o    = tv_v_r & hit_found;
  assign retire    = tv_v_o & yumi_i;
  assign advance_o = ~tv_v_r | retire;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r <= 1'b0;
    end
    else if (advance_o) begin
      tv_v_r <= tl_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_o & tl_v_i) begin
      tv_decode_r <= tl_decode_i;
      tv_addr_r   <= tl_addr_i;
      tv_data_r   <= tl_data_i;
    end
  end

  // store lanes and replicated store data
  always_comb begin
    case (tv_decode_r.size)
      size_byte: begin
        byte_en = 4'b0001 << tv_addr_r.f.byte_off;
        st_word = {4{tv_data_r[7:0]}};
      end
      size_half: begin
        byte_en = 4'b0011 << {tv_addr_r.f.byte_off[1], 1'b0};
        st_word = {2{tv_data_r[15:0]}};
      end
      default: begin
        byte_en = 4'b1111;
        st_word = tv_data_r;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_c; s++) begin
        meta_r[s] <= '0;
        stat_r[s] <= '0;
      end
    end
    else begin
      if (retire) begin
        stat_r[idx].lru <= ~hit_way;
        if (tv_decode_r.st_op) begin
          stat_r[idx].dirty[hit_way] <= 1'b1;
        end
      end
      // done doubles as the tag write strobe
      if (miss.done) begin
        meta_r[idx][miss.fill_way] <= {1'b1, tv_addr_r.f.tag};
        stat_r[idx].dirty[miss.fill_way] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss.fill_we) begin
      data_r[idx][miss.fill_way][miss.fill_offset] <= miss.fill_data;
    end
    if (retire & tv_decode_r.st_op) begin
      for (int b = 0; b < word_width_c / 8; b++) begin
        if (byte_en[b]) begin
          data_r[idx][hit_way][tv_addr_r.f.word_off][8*b +: 8] <= st_word[8*b +: 8];
        end
      end
    end
  end

  assign hit_word_o  = data_r[idx][hit_way][tv_addr_r.f.word_off];
  assign tv_decode_o = tv_decode_r;
  assign tv_addr_o   = tv_addr_r;

  assign miss.miss_v     = tv_v_r & ~hit_found;
  assign miss.miss_addr  = tv_addr_r;
  assign miss.meta       = meta_r[idx];
  assign miss.stat       = stat_r[idx];
  assign miss.evict_data = data_r[idx][miss.fill_way][miss.evict_offset];

  a_one_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    tv_v_r |-> $countones(hit_v) <= 1)
    else $error("more than one way hit");

  a_done_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    miss.done |-> miss.miss_v)
    else $error("miss done without a pending miss");

endmodule

// File: logic/cache_decode.sv
`timescale 1ns/1ps

module cache_decode (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  cache_op_pkg::cache_op_e     cache_op_i,
  input  cache_cfg_pkg::cache_addr_u  addr_i,
  input  cache_cfg_pkg::word_t        data_i,
  input  logic                        v_i,
  output logic                        ready_o,
  input  logic                        advance_i,
  output logic                        tl_v_o,
  output cache_op_pkg::cache_decode_s tl_decode_o,
  output cache_cfg_pkg::cache_addr_u  tl_addr_o,
  output cache_cfg_pkg::word_t        tl_data_o
);
  import cache_cfg_pkg::*;
  import cache_op_pkg::*;

  cache_decode_s decode;
  logic          tl_v_r;
  cache_decode_s tl_decode_r;
  cache_addr_u   tl_addr_r;
  word_t         tl_data_r;

  always_comb begin
    case (cache_op_i)
      op_lb:   decode = '{st_op: 1'b0, size: size_byte, sigext: 1'b1};
      op_lbu:  decode = '{st_op: 1'b0, size: size_byte, sigext: 1'b0};
      op_lh:   decode = '{st_op: 1'b0, size: size_half, sigext: 1'b1};
      op_lhu:  decode = '{st_op: 1'b0, size: size_half, sigext: 1'b0};
      op_sb:   decode = '{st_op: 1'b1, size: size_byte, sigext: 1'b0};
      op_sh:   decode = '{st_op: 1'b1, size: size_half, sigext: 1'b0};
      op_sw:   decode = '{st_op: 1'b1, size: size_word, sigext: 1'b0};
      default: decode = '{st_op: 1'b0, size: size_word, sigext: 1'b0};
    endcase
  end

  // TL moves on only when TV can take its entry
  assign ready_o = ~tl_v_r | advance_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
    end
    else if (ready_o) begin
      tl_v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o & v_i) begin
      tl_decode_r <= decode;
      tl_addr_r   <= addr_i;
      tl_data_r   <= data_i;
    end
  end

  assign tl_v_o      = tl_v_r;
  assign tl_decode_o = tl_decode_r;
  assign tl_addr_o   = tl_addr_r;
  assign tl_data_o   = tl_data_r;

  a_legal_op: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i && ready_o |-> !$isunknown(cache_op_i))
    else $error("unknown opcode accepted");

endmodule

// File: logic/cache_miss_if.sv
`timescale 1ns/1ps

interface cache_miss_if;
  import cache_cfg_pkg::*;

  // lookup side
  logic                       miss_v;
  cache_addr_u                miss_addr;
  way_meta_s [ways_c-1:0]     meta;
  set_stat_s                  stat;
  word_t                      evict_data;

  // miss engine side
  logic                       done;
  logic [lg_ways_c-1:0]       fill_way;
  logic                       fill_we;
  logic [lg_block_c-1:0]      fill_offset;
  word_t                      fill_data;
  logic [lg_block_c-1:0]      evict_offset;

  modport lookup (
    output miss_v, miss_addr, meta, stat, evict_data,
    input  done, fill_way, fill_we, fill_offset, fill_data, evict_offset
  );

  modport miss (
    input  miss_v, miss_addr, meta, stat, evict_data,
    output done, fill_way, fill_we, fill_offset, fill_data, evict_offset
  );

endinterface

// File: logic/cache_op_pkg.sv
package cache_op_pkg;

  typedef enum logic [2:0] {
    op_lb  = 3'd0,
    op_lbu = 3'd1,
    op_lh  = 3'd2,
    op_lhu = 3'd3,
    op_lw  = 3'd4,
    op_sb  = 3'd5,
    op_sh  = 3'd6,
    op_sw  = 3'd7
  } cache_op_e;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_e;

  typedef struct packed {
    logic  st_op;
    size_e size;
    logic  sigext;
  } cache_decode_s;

endpackage

// File: logic/cache_cfg_pkg.sv
package cache_cfg_pkg;

  // cache geometry
  localparam int word_width_c  = 32;
  localparam int addr_width_c  = 16;
  localparam int ways_c        = 2;
  localparam int sets_c        = 16;
  localparam int block_words_c = 4;

  localparam int lg_ways_c   = $clog2(ways_c);
  localparam int lg_sets_c   = $clog2(sets_c);
  localparam int lg_block_c  = $clog2(block_words_c);
  localparam int byte_off_c  = $clog2(word_width_c / 8);
  localparam int tag_width_c = addr_width_c - lg_sets_c - lg_block_c - byte_off_c;

  typedef logic [word_width_c-1:0] word_t;

  typedef struct packed {
    logic [tag_width_c-1:0] tag;
    logic [lg_sets_c-1:0]   index;
    logic [lg_block_c-1:0]  word_off;
    logic [byte_off_c-1:0]  byte_off;
  } cache_addr_fields_s;

  // flat byte address or split fields
  typedef union packed {
    logic [addr_width_c-1:0] flat;
    cache_addr_fields_s      f;
  } cache_addr_u;

  typedef struct packed {
    logic                   valid;
    logic [tag_width_c-1:0] tag;
  } way_meta_s;

  // lru names the way to evict next
  typedef struct packed {
    logic [ways_c-1:0] dirty;
    logic [ways_c-2:0] lru;
  } set_stat_s;

endpackage
